//--- Makefile
VERILATOR ?= verilator
TOP       ?= multTb
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAILMSG   ?= Some tests failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAILMSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- all.f
+incdir+hdl
hdl/multPkg.sv
hdl/multControl.sv
hdl/multDatapath.sv
hdl/apbMultRegs.sv
hdl/multTop.sv
bench/clockGen.sv
bench/multTop_chk.sv
bench/multTb.sv

//--- bench/clockGen.sv
`timescale 1ns/1ps

module clockGen
(
  output logic CLk,
  output logic reset
);

  // 10 ns period, starts low
  initial
  begin
    CLk = 1'b0;
    forever
      #5 CLk = ~CLk;
  end

  // held over two rising edges
  // released on a falling edge like the other inputs
  initial
  begin
    reset = 1'b1;
    repeat (2)
      @(posedge CLk);
    @(negedge CLk);
    reset = 1'b0;
  end

endmodule

//--- bench/multTb.sv
`timescale 1ns/1ps

`include "mult_cfg.svh"

module multTb;

  logic                    CLk;
  logic                    reset;
  logic                    PSEL;
  logic                    PENABLE;
  logic                    PWRITE;
  logic [3:0]              PADDR;
  logic [`MULT_APB_DW-1:0] PWDATA;
  logic [`MULT_APB_DW-1:0] PRDATA;

  int          errors;
  int          checks;
  // random operand source
  logic [15:0] lfsr;

  clockGen clockGen_inst
  (
    .CLk   (CLk),
    .reset (reset)
  );

  multTop multTop_inst
  (
    .CLk     (CLk),
    .reset   (reset),
    .PSEL    (PSEL),
    .PENABLE (PENABLE),
    .PWRITE  (PWRITE),
    .PADDR   (PADDR),
    .PWDATA  (PWDATA),
    .PRDATA  (PRDATA)
  );

  // closing summary line and the verdict
  task automatic finishRun();
  begin
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end
  endtask

  task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                input logic [31:0] gotVal);
  begin
    errors++;
    $display("FAIL t=%0t %s expected %h got %h", $time, name, expVal, gotVal);
  end
  endtask

  // setup cycle then access cycle on falling edges
  task automatic apbWrite(input logic [3:0] addr, input logic [`MULT_APB_DW-1:0] data);
  begin
    PSEL    = 1'b1;
    PWRITE  = 1'b1;
    PADDR   = addr;
    PWDATA  = data;
    PENABLE = 1'b0;
    @(negedge CLk);
    PENABLE = 1'b1;
    @(negedge CLk);
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
  end
  endtask

  task automatic apbRead(input logic [3:0] addr, output logic [`MULT_APB_DW-1:0] data);
  begin
    PSEL    = 1'b1;
    PWRITE  = 1'b0;
    PADDR   = addr;
    PENABLE = 1'b0;
    @(negedge CLk);
    PENABLE = 1'b1;
    // sampled mid low phase well clear of the access edge
    #1;
    data = PRDATA;
    @(negedge CLk);
    PSEL    = 1'b0;
    PENABLE = 1'b0;
  end
  endtask

  task automatic readCheck(input logic [3:0] addr, input logic [31:0] expected,
                           input string name);
    logic [31:0] got;
  begin
    apbRead(addr, got);
    checks++;
    if (got !== expected)
      reportMismatch(name, expected, got);
  end
  endtask

  // poll STAT until busy clears or the poll limit runs out
  task automatic waitIdle();
    logic [31:0] stat;
    int          polls;
  begin
    polls = 0;
    apbRead(`MULT_ADDR_STAT, stat);
    while (stat[0] && polls < 20)
    begin
      polls++;
      apbRead(`MULT_ADDR_STAT, stat);
    end
    if (stat[0])
    begin
      $display("ERROR: busy still set after %0d status polls", polls);
      errors++;
    end
  end
  endtask

  // operands widened to 16 bits before the signed multiply
  function automatic logic [15:0] signedProduct(input logic [7:0] a, input logic [7:0] b);
    logic signed [15:0] p;
  begin
    p = $signed({{8{a[7]}}, a}) * $signed({{8{b[7]}}, b});
    return p;
  end
  endfunction

  // Galois step for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrNext(input logic [15:0] cur);
  begin
    if (cur[0])
      return (cur >> 1) ^ 16'hB400;
    return cur >> 1;
  end
  endfunction

  // one step per bit taken
  task automatic randomByte(output logic [7:0] value);
  begin
    for (int i = 0; i < 8; i++)
    begin
      value = {value[6:0], lfsr[0]};
      lfsr  = lfsrNext(lfsr);
    end
  end
  endtask

  // load both operands, start, wait, compare the whole STAT word
  task automatic runMult(input logic [7:0] s, input logic [7:0] b, input logic [15:0] expected);
  begin
    apbWrite(`MULT_ADDR_S, {24'h0, s});
    apbWrite(`MULT_ADDR_B, {24'h0, b});
    apbWrite(`MULT_ADDR_CTRL, 32'h1);
    waitIdle();
    readCheck(`MULT_ADDR_STAT, {expected, 16'h0}, "STAT");
  end
  endtask

  initial
  begin : mainFlow
    int          fd;
    int          fields;
    int          waitCycles;
    int          patternCount;
    string       line;
    logic [7:0]  s;
    logic [7:0]  b;
    logic [15:0] p;
    logic [7:0]  s2;
    logic [7:0]  b2;
    logic [31:0] stat;
    PSEL         = 1'b0;
    PENABLE      = 1'b0;
    PWRITE       = 1'b0;
    PADDR        = 4'h0;
    PWDATA       = '0;
    errors       = 0;
    checks       = 0;
    patternCount = 0;
    lfsr         = 16'd27812;

    // wait out reset on rising edges where it is stable
    waitCycles = 0;
    @(posedge CLk);
    while (reset !== 1'b0 && waitCycles < 10)
    begin
      waitCycles++;
      @(posedge CLk);
    end
    if (reset !== 1'b0)
    begin
      $display("ERROR: reset was never released");
      errors++;
    end
    @(negedge CLk);

    // idle and zero after reset
    readCheck(`MULT_ADDR_STAT, 32'h0, "STAT");

    // only the low byte is kept
    apbWrite(`MULT_ADDR_S, 32'hFFFF_FF5A);
    apbWrite(`MULT_ADDR_B, 32'h1234_56A5);
    readCheck(`MULT_ADDR_S, 32'h5A, "S");
    readCheck(`MULT_ADDR_B, 32'hA5, "B");
    readCheck(4'h2, 32'h0, "PRDATA at 0x2");
    readCheck(4'hE, 32'h0, "PRDATA at 0xE");

    // directed pairs
    fd = $fopen("bench/mult_patterns.txt", "r");
    if (fd == 0)
    begin
      $display("ERROR: cannot open bench/mult_patterns.txt");
      errors++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line   = "";
        fields = $fgets(line, fd);
        // comment and blank lines give fewer than three fields
        fields = $sscanf(line, "%h %h %h", s, b, p);
        if (fields == 3)
        begin
          patternCount++;
          checks++;
          if (p !== signedProduct(s, b))
          begin
            $display("ERROR: pattern %h x %h lists product %h", s, b, p);
            errors++;
          end
          runMult(s, b, p);
        end
      end
      $fclose(fd);
    end
    if (patternCount == 0)
    begin
      $display("ERROR: no operand pairs found in the pattern file");
      errors++;
    end

    // random pairs
    for (int i = 0; i < 200; i++)
    begin
      randomByte(s);
      randomByte(b);
      runMult(s, b, signedProduct(s, b));
    end

    // -45 x 107 in flight with 113 x -120 written behind it
    s  = 8'hD3;
    b  = 8'h6B;
    s2 = 8'h71;
    b2 = 8'h88;
    apbWrite(`MULT_ADDR_S, {24'h0, s});
    apbWrite(`MULT_ADDR_B, {24'h0, b});
    apbWrite(`MULT_ADDR_CTRL, 32'h1);
    apbWrite(`MULT_ADDR_S, {24'h0, s2});
    apbWrite(`MULT_ADDR_B, {24'h0, b2});
    // dropped because the run is still busy
    apbWrite(`MULT_ADDR_CTRL, 32'h1);
    apbRead(`MULT_ADDR_STAT, stat);
    checks++;
    if (stat[0] !== 1'b1)
      reportMismatch("STAT.busy", 32'h1, {31'h0, stat[0]});
    waitIdle();
    readCheck(`MULT_ADDR_STAT, {signedProduct(s, b), 16'h0}, "STAT");
    readCheck(`MULT_ADDR_S, {24'h0, s2}, "S");
    readCheck(`MULT_ADDR_B, {24'h0, b2}, "B");
    // next start picks up the new copies
    apbWrite(`MULT_ADDR_CTRL, 32'h1);
    waitIdle();
    readCheck(`MULT_ADDR_STAT, {signedProduct(s2, b2), 16'h0}, "STAT");

    finishRun();
  end

endmodule

//--- bench/multTop_chk.sv
`timescale 1ns/1ps

`include "mult_cfg.svh"

module multTop_chk
(
  input logic                    CLk,
  input logic                    reset,
  input logic                    start,
  input logic                    busy,
  input logic                    PSEL,
  input logic [`MULT_APB_DW-1:0] PRDATA
);

  // start is a single-cycle pulse
  startPulse: assert property (@(posedge CLk) disable iff (reset) start |=> !start)
    else $error("start held high for more than one cycle");

  // start taken at edge k, busy seen low from edge k+10
  busyFall: assert property (@(posedge CLk) disable iff (reset) $past(start, 10) |-> $fell(busy))
    else $error("busy did not fall nine cycles after start");

  // and busy never drops at any other time
  busyFallCause: assert property (@(posedge CLk) disable iff (reset)
    $fell(busy) |-> $past(start, 10))
    else $error("busy fell without a start ten edges earlier");

  // read data is gated by PSEL
  idleBus: assert property (@(posedge CLk) !PSEL |-> PRDATA == '0)
    else $error("PRDATA not zero while PSEL is low");

endmodule

bind multTop multTop_chk multTop_chk_inst
(
  .CLk    (CLk),
  .reset  (reset),
  .start  (start),
  .busy   (busy),
  .PSEL   (PSEL),
  .PRDATA (PRDATA)
);

//--- bench/mult_patterns.txt
// multiplicand multiplier product, all hex, two's complement
// one pair per line
00 00 0000
01 01 0001
FF 01 FFFF
01 FF FFFF
FF FF 0001
7F 7F 3F01
80 80 4000
80 7F C080
7F 80 C080
00 80 0000
05 FD FFF1
F9 09 FFC1
0C 0A 0078
9C 9C 2710
80 01 FF80
01 80 FF80
64 CE EC78
FF 80 0080

//--- hdl/apbMultRegs.sv
`timescale 1ns/1ps

`include "mult_cfg.svh"

module apbMultRegs
(
  input  logic                    CLk,
  input  logic                    reset,
  input  logic                    PSEL,
  input  logic                    PENABLE,
  input  logic                    PWRITE,
  input  logic [3:0]              PADDR,
  input  logic [`MULT_APB_DW-1:0] PWDATA,
  output logic [`MULT_APB_DW-1:0] PRDATA,
  input  logic                    busy,
  input  logic [15:0]             product,
  output multPkg::operandsT       operands,
  output logic                    start
);

  // write strobe in the access phase, no wait states
  logic wrAccess;

  // read data before the PSEL gate
  logic [`MULT_APB_DW-1:0] rdData;

  assign wrAccess = PSEL && PENABLE && PWRITE;

  // operand copies, writable at any time
  // the datapath only samples them at the load step
  always_ff @(posedge CLk)
  begin
    if (reset)
    begin
      operands.multiplicand <= 8'h00;
      operands.multiplier   <= 8'h00;
    end
    else if (wrAccess)
    begin
      if (PADDR == `MULT_ADDR_S)
        operands.multiplicand <= PWDATA[7:0];
      if (PADDR == `MULT_ADDR_B)
        operands.multiplier <= PWDATA[7:0];
    end
  end

  // one-cycle pulse, dropped while a run is in progress
  assign start = wrAccess && (PADDR == `MULT_ADDR_CTRL) && PWDATA[0] && !busy;

  // read mux
  // CTRL is a write-only command and reads as zero like unmapped space
  always_comb
  begin
    case (PADDR)
      `MULT_ADDR_S:
        rdData = {{(`MULT_APB_DW-8){1'b0}}, operands.multiplicand};
      `MULT_ADDR_B:
        rdData = {{(`MULT_APB_DW-8){1'b0}}, operands.multiplier};
      `MULT_ADDR_STAT:
        rdData = {product, {(`MULT_APB_DW-17){1'b0}}, busy};
      default:
        rdData = '0;
    endcase
  end

  // bus is quiet when not selected
  assign PRDATA = PSEL ? rdData : '0;

endmodule

//--- hdl/multControl.sv
`timescale 1ns/1ps

module multControl
(
  input  logic         CLk,
  input  logic         reset,
  input  logic         start,
  input  logic         m,
  output multPkg::ctrlT ctrl,
  output logic         busy
);

  import multPkg::*;

  stateT state;
  stateT nextState;

  // state register
  always_ff @(posedge CLk)
  begin
    if (reset)
      state <= sIdle;
    else
      state <= nextState;
  end

  // sequencing, start is already masked while busy
  always_comb
  begin
    nextState = state;
    unique case (state)
      sIdle:
      begin
        if (start)
          nextState = sLoad;
      end
      sLoad: nextState = sAdd0;
      sAdd0: nextState = sAdd1;
      sAdd1: nextState = sAdd2;
      sAdd2: nextState = sAdd3;
      sAdd3: nextState = sAdd4;
      sAdd4: nextState = sAdd5;
      sAdd5: nextState = sAdd6;
      // last multiplier bit is the sign bit, so it gets weight -2^7
      sAdd6: nextState = sSub;
      sSub:  nextState = sIdle;
      default: nextState = sIdle;
    endcase
  end

  // datapath controls decoded from the current state and B[0]
  always_comb
  begin
    ctrl.op    = opNone;
    ctrl.shift = 1'b0;
    ctrl.clrLd = 1'b0;
    case (state)
      sLoad: ctrl.clrLd = 1'b1;
      sAdd0, sAdd1, sAdd2, sAdd3, sAdd4, sAdd5, sAdd6:
      begin
        ctrl.shift = 1'b1;
        // add S only when the current multiplier bit is set
        if (m)
          ctrl.op = opAdd;
      end
      sSub:
      begin
        ctrl.shift = 1'b1;
        if (m)
          ctrl.op = opSub;
      end
      default: ctrl.op = opNone;
    endcase
  end

  // low only while waiting for a start
  assign busy = (state != sIdle);

endmodule

//--- hdl/multDatapath.sv
`timescale 1ns/1ps

module multDatapath
(
  input  logic            CLk,
  input  logic            reset,
  input  multPkg::ctrlT   ctrl,
  input  multPkg::operandsT operands,
  output logic            m,
  output logic [15:0]     product
);

  import multPkg::*;

  // carry/sign bit, accumulator, multiplier and multiplicand
  logic       x;
  logic [7:0] a;
  logic [7:0] b;
  logic [7:0] s;

  // 9-bit working values
  logic [8:0] accExt;
  logic [8:0] sExt;
  logic [8:0] sum;

  // X acts as the sign extension of A
  assign accExt = {x, a};
  assign sExt   = {s[7], s};

  // add or subtract S before the shift, same cycle
  always_comb
  begin
    case (ctrl.op)
      opAdd:   sum = accExt + sExt;
      opSub:   sum = accExt - sExt;
      default: sum = accExt;
    endcase
  end

  // 17-bit chain {X,A,B}, load wins over shift
  always_ff @(posedge CLk)
  begin
    if (reset)
    begin
      x <= 1'b0;
      a <= 8'h00;
      b <= 8'h00;
    end
    else if (ctrl.clrLd)
    begin
      x <= 1'b0;
      a <= 8'h00;
      b <= operands.multiplier;
    end
    else if (ctrl.shift)
    begin
      // arithmetic right shift, sign bit stays in X
      x <= sum[8];
      a <= sum[8:1];
      // A LSB drops into B MSB
      b <= {sum[0], b[7:1]};
    end
  end

  // multiplicand only changes at the load step
  always_ff @(posedge CLk)
  begin
    if (ctrl.clrLd)
      s <= operands.multiplicand;
  end

  assign m       = b[0];
  assign product = {a, b};

endmodule

//--- hdl/multPkg.sv
package multPkg;

  // controller states
  // one clear/load step, seven add-and-shift steps, one subtract-and-shift step
  typedef enum logic [3:0]
  {
    sIdle,
    sLoad,
    sAdd0,
    sAdd1,
    sAdd2,
    sAdd3,
    sAdd4,
    sAdd5,
    sAdd6,
    sSub
  } stateT;

  // arithmetic applied to {X,A} before the shift
  typedef enum logic [1:0]
  {
    opNone,
    opAdd,
    opSub
  } opT;

  // per-cycle controls from the FSM to the datapath
  typedef struct packed
  {
    opT   op;
    // arithmetic right shift of {X,A,B}
    logic shift;
    // clear X and A, load B and S
    logic clrLd;
  } ctrlT;

  // operand copies held by the register file
  typedef struct packed
  {
    logic [7:0] multiplicand;
    logic [7:0] multiplier;
  } operandsT;

endpackage

//--- hdl/multTop.sv
`timescale 1ns/1ps

`include "mult_cfg.svh"

module multTop
(
  input  logic                    CLk,
  input  logic                    reset,
  input  logic                    PSEL,
  input  logic                    PENABLE,
  input  logic                    PWRITE,
  input  logic [3:0]              PADDR,
  input  logic [`MULT_APB_DW-1:0] PWDATA,
  output logic [`MULT_APB_DW-1:0] PRDATA
);

  import multPkg::*;

  // register file to controller and datapath
  logic     start;
  operandsT operands;

  // controller outputs
  ctrlT ctrl;
  logic busy;

  // datapath outputs
  logic        m;
  logic [15:0] product;

  apbMultRegs apbMultRegs_inst
  (
    .CLk      (CLk),
    .reset    (reset),
    .PSEL     (PSEL),
    .PENABLE  (PENABLE),
    .PWRITE   (PWRITE),
    .PADDR    (PADDR),
    .PWDATA   (PWDATA),
    .PRDATA   (PRDATA),
    .busy     (busy),
    .product  (product),
    .operands (operands),
    .start    (start)
  );

  multControl multControl_inst
  (
    .CLk   (CLk),
    .reset (reset),
    .start (start),
    .m     (m),
    .ctrl  (ctrl),
    .busy  (busy)
  );

  multDatapath multDatapath_inst
  (
    .CLk      (CLk),
    .reset    (reset),
    .ctrl     (ctrl),
    .operands (operands),
    .m        (m),
    .product  (product)
  );

endmodule

//--- hdl/mult_cfg.svh
`ifndef MULT_CFG_SVH
`define MULT_CFG_SVH

// APB data bus width
`define MULT_APB_DW 32

// register map, byte addresses on the 4-bit PADDR

// multiplicand S, low 8 bits
`define MULT_ADDR_S 4'h0

// multiplier B, low 8 bits
`define MULT_ADDR_B 4'h4

// command, bit 0 written as 1 starts a run
`define MULT_ADDR_CTRL 4'h8

// status, busy in bit 0 and product in bits 31:16
`define MULT_ADDR_STAT 4'hC

`endif
